/* common/dmem_if.sv */
`timescale 1ns/100ps

interface dmem_if;
    import lsq_pkg::*;

    logic  req;
    word_t addr;
    mask_t rmask;
    mask_t wmask;
    word_t wdata;
    word_t rdata;
    logic  resp;
    logic  full;

    modport queue (output req, addr, rmask, wmask, wdata, input rdata, resp, full);

    modport buffer (input req, addr, rmask, wmask, wdata, output rdata, resp, full);

endinterface

/* common/lsq_defines.svh */
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// queue and buffer sizes
`define LSQ_DEPTH 8
`define SB_DEPTH 4

// data SRAM size in 32-bit words
`define SRAM_WORDS 256

// tag widths shared with the rest of the core
`define ROB_BITS 5
`define PHYS_BITS 6
`define ARCH_BITS 5

`endif

/* common/lsq_pkg.sv */
`include "lsq_defines.svh"

package lsq_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] mask_t;
    typedef logic [`ROB_BITS-1:0] rob_idx_t;
    typedef logic [`PHYS_BITS-1:0] phys_reg_t;
    typedef logic [`ARCH_BITS-1:0] arch_reg_t;
    typedef logic [$clog2(`LSQ_DEPTH)-1:0] lsq_idx_t;

    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } mem_op_e;

    // loads and stores share the width encoding
    typedef enum logic [2:0] {
        f3_byte   = 3'b000,
        f3_half   = 3'b001,
        f3_word   = 3'b010,
        f3_byte_u = 3'b100,
        f3_half_u = 3'b101
    } mem_funct3_e;

    typedef struct packed {
        logic        valid;
        logic        addr_ready;
        logic        issued;
        mem_op_e     op;
        mem_funct3_e funct3;
        rob_idx_t    rob;
        phys_reg_t   pd;
        arch_reg_t   rd;
        word_t       addr;
        word_t       store_data;
    } lsq_entry_t;

endpackage

/* common/sram_if.sv */
`timescale 1ns/100ps
`include "lsq_defines.svh"

interface sram_if;
    import lsq_pkg::*;

    logic                            en;
    logic                            we;
    logic [$clog2(`SRAM_WORDS)-1:0] addr;
    mask_t                           wmask;
    word_t                           wdata;
    word_t                           rdata;

    modport controller (output en, we, addr, wmask, wdata, input rdata);

    modport memory (input en, we, addr, wmask, wdata, output rdata);

endinterface

/* mem_queue/mem_lane_format.sv */
`timescale 1ns/100ps

module mem_lane_format (
    input  lsq_pkg::mem_funct3_e funct3,
    input  logic                 is_store,
    input  logic [1:0]           byte_off,
    input  lsq_pkg::word_t       store_data,
    input  lsq_pkg::word_t       load_word,
    output lsq_pkg::mask_t       rmask,
    output lsq_pkg::mask_t       wmask,
    output lsq_pkg::word_t       wdata,
    output lsq_pkg::word_t       load_value
);
    import lsq_pkg::*;

    mask_t base_mask;
    word_t lanes;

    always_comb begin
        case (funct3)
            f3_byte, f3_byte_u: base_mask = 4'b0001;
            f3_half, f3_half_u: base_mask = 4'b0011;
            default:            base_mask = 4'b1111;
        endcase
    end

    assign rmask = is_store ? 4'b0000 : base_mask << byte_off;
    assign wmask = is_store ? base_mask << byte_off : 4'b0000;
    assign wdata = store_data << {byte_off, 3'b000};

    // selected lanes moved down to bit 0
    assign lanes = load_word >> {byte_off, 3'b000};

    always_comb begin
        case (funct3)
            f3_byte:   load_value = {{24{lanes[7]}}, lanes[7:0]};
            f3_byte_u: load_value = {24'd0, lanes[7:0]};
            f3_half:   load_value = {{16{lanes[15]}}, lanes[15:0]};
            f3_half_u: load_value = {16'd0, lanes[15:0]};
            default:   load_value = load_word;
        endcase
    end

endmodule

/* mem_queue/mem_queue.sv */
`timescale 1ns/100ps
`include "lsq_defines.svh"

module mem_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 enq_valid,
    input  lsq_pkg::mem_op_e     enq_op,
    input  lsq_pkg::mem_funct3_e enq_funct3,
    input  lsq_pkg::rob_idx_t    enq_rob,
    input  lsq_pkg::phys_reg_t   enq_pd,
    input  lsq_pkg::arch_reg_t   enq_rd,
    output lsq_pkg::lsq_idx_t    enq_idx,
    output logic                 full,
    input  logic                 addr_valid,
    input  lsq_pkg::lsq_idx_t    addr_idx,
    input  lsq_pkg::word_t       addr,
    input  lsq_pkg::word_t       store_data,
    input  lsq_pkg::rob_idx_t    commit_rob,
    dmem_if.queue                dmem,
    output logic                 cdb_valid,
    output lsq_pkg::rob_idx_t    cdb_rob,
    output lsq_pkg::phys_reg_t   cdb_pd,
    output lsq_pkg::arch_reg_t   cdb_rd,
    output lsq_pkg::word_t       cdb_value
);
    import lsq_pkg::*;

    localparam int PTR_W = $clog2(`LSQ_DEPTH);

    lsq_entry_t     entries [`LSQ_DEPTH];
    logic [PTR_W:0] head;
    logic [PTR_W:0] tail;
    lsq_entry_t     hd;
    logic           hd_store;
    logic           issue;
    logic           pop;
    logic [1:0]     discard_cnt;
    mask_t          lane_rmask;
    mask_t          lane_wmask;
    word_t          lane_wdata;
    word_t          load_value;

    assign hd = entries[head[PTR_W-1:0]];
    assign hd_store = (hd.op == op_store);

    // wrap bit tells full from empty
    assign full = (head[PTR_W] != tail[PTR_W]) && (head[PTR_W-1:0] == tail[PTR_W-1:0]);
    assign enq_idx = tail[PTR_W-1:0];

    // no new request while a flushed response is still owed
    assign issue = hd.valid && hd.addr_ready && !hd.issued && (hd.rob == commit_rob)
                   && (!hd_store || !dmem.full) && (discard_cnt == '0) && !flush;

    assign pop = dmem.resp && (discard_cnt == '0) && !flush;

    mem_lane_format lane_inst (
        .funct3     (hd.funct3),
        .is_store   (hd_store),
        .byte_off   (hd.addr[1:0]),
        .store_data (hd.store_data),
        .load_word  (dmem.rdata),
        .rmask      (lane_rmask),
        .wmask      (lane_wmask),
        .wdata      (lane_wdata),
        .load_value (load_value)
    );

    assign dmem.req = issue;
    assign dmem.addr = {hd.addr[31:2], 2'b00};
    assign dmem.rmask = lane_rmask;
    assign dmem.wmask = lane_wmask;
    assign dmem.wdata = lane_wdata;

    assign cdb_valid = pop;
    assign cdb_rob = hd.rob;
    assign cdb_pd = hd.pd;
    assign cdb_rd = hd_store ? '0 : hd.rd;
    assign cdb_value = hd_store ? '0 : load_value;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].addr_ready <= 1'b0;
                entries[i].issued <= 1'b0;
            end
        end else begin
            if (enq_valid && !full) begin
                tail <= tail + 1'b1;
                entries[enq_idx].valid <= 1'b1;
                entries[enq_idx].addr_ready <= 1'b0;
                entries[enq_idx].issued <= 1'b0;
                entries[enq_idx].op <= enq_op;
                entries[enq_idx].funct3 <= enq_funct3;
                entries[enq_idx].rob <= enq_rob;
                entries[enq_idx].pd <= enq_pd;
                entries[enq_idx].rd <= enq_rd;
            end
            if (addr_valid) begin
                entries[addr_idx].addr_ready <= 1'b1;
                entries[addr_idx].addr <= addr;
                entries[addr_idx].store_data <= store_data;
            end
            if (issue) begin
                entries[head[PTR_W-1:0]].issued <= 1'b1;
            end
            if (pop) begin
                entries[head[PTR_W-1:0]].valid <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

    // responses still in flight when the queue is flushed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            discard_cnt <= '0;
        end else if (flush && hd.valid && hd.issued && !dmem.resp) begin
            discard_cnt <= discard_cnt + 2'd1;
        end else if (dmem.resp && discard_cnt != '0) begin
            discard_cnt <= discard_cnt - 2'd1;
        end
    end

    // the head stays issued until its response pops it
    single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        dmem.req |=> !dmem.req);

    resp_has_request: assert property (@(posedge clk) disable iff (!rst_n)
        dmem.resp |-> (discard_cnt != '0) || (hd.valid && hd.issued));

endmodule

/* rtl/data_sram.sv */
`timescale 1ns/100ps
`include "lsq_defines.svh"

module data_sram (
    input logic    clk,
    sram_if.memory sram
);
    import lsq_pkg::*;

    word_t mem [`SRAM_WORDS];

    // read data lands one cycle after en
    always_ff @(posedge clk) begin
        if (sram.en) begin
            if (sram.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sram.wmask[b]) begin
                        mem[sram.addr][8*b +: 8] <= sram.wdata[8*b +: 8];
                    end
                end
            end else begin
                sram.rdata <= mem[sram.addr];
            end
        end
    end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/100ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 enq_valid,
    input  lsq_pkg::mem_op_e     enq_op,
    input  lsq_pkg::mem_funct3_e enq_funct3,
    input  lsq_pkg::rob_idx_t    enq_rob,
    input  lsq_pkg::phys_reg_t   enq_pd,
    input  lsq_pkg::arch_reg_t   enq_rd,
    output lsq_pkg::lsq_idx_t    enq_idx,
    input  logic                 addr_valid,
    input  lsq_pkg::lsq_idx_t    addr_idx,
    input  lsq_pkg::word_t       addr,
    input  lsq_pkg::word_t       store_data,
    input  lsq_pkg::rob_idx_t    commit_rob,
    output logic                 cdb_valid,
    output lsq_pkg::rob_idx_t    cdb_rob,
    output lsq_pkg::phys_reg_t   cdb_pd,
    output lsq_pkg::arch_reg_t   cdb_rd,
    output lsq_pkg::word_t       cdb_value,
    output logic                 full
);

    dmem_if dmem ();
    sram_if sram ();

    mem_queue mem_queue_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .enq_valid  (enq_valid),
        .enq_op     (enq_op),
        .enq_funct3 (enq_funct3),
        .enq_rob    (enq_rob),
        .enq_pd     (enq_pd),
        .enq_rd     (enq_rd),
        .enq_idx    (enq_idx),
        .full       (full),
        .addr_valid (addr_valid),
        .addr_idx   (addr_idx),
        .addr       (addr),
        .store_data (store_data),
        .commit_rob (commit_rob),
        .dmem       (dmem),
        .cdb_valid  (cdb_valid),
        .cdb_rob    (cdb_rob),
        .cdb_pd     (cdb_pd),
        .cdb_rd     (cdb_rd),
        .cdb_value  (cdb_value)
    );

    // committed stores survive a flush here
    store_buffer store_buffer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .dmem  (dmem),
        .sram  (sram)
    );

    data_sram data_sram_inst (
        .clk  (clk),
        .sram (sram)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_lsu_top -Mdir obj_dir -o tb_lsu_top > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

/* sources.f */
+incdir+common
common/lsq_pkg.sv
common/dmem_if.sv
common/sram_if.sv
mem_queue/mem_lane_format.sv
mem_queue/mem_queue.sv
store_buffer/store_buffer.sv
rtl/data_sram.sv
rtl/lsu_top.sv
tests/tb_lsu_top.sv

/* store_buffer/store_buffer.sv */
`timescale 1ns/100ps
`include "lsq_defines.svh"

module store_buffer (
    input logic        clk,
    input logic        rst_n,
    dmem_if.buffer     dmem,
    sram_if.controller sram
);
    import lsq_pkg::*;

    localparam int SB_W = $clog2(`SB_DEPTH);
    localparam int SRAM_AW = $clog2(`SRAM_WORDS);

    word_t           sb_addr [`SB_DEPTH];
    mask_t           sb_mask [`SB_DEPTH];
    word_t           sb_data [`SB_DEPTH];
    logic [SB_W:0]   head;
    logic [SB_W:0]   tail;
    logic [SB_W:0]   count;
    logic [SB_W-1:0] scan_slot;
    logic            push;
    logic            drain;
    logic            ld_wait;
    word_t           ld_addr_q;
    mask_t           ld_mask_q;
    word_t           ld_addr;
    mask_t           ld_mask;
    logic            ld_active;
    logic            hit;
    mask_t           hit_mask;
    word_t           hit_data;
    logic            ld_fwd;
    logic            ld_sram;
    logic            resp_q;
    logic            fwd_q;
    word_t           fwd_data;

    assign count = tail - head;
    assign dmem.full = (count == (SB_W + 1)'(`SB_DEPTH));
    assign push = dmem.req && (dmem.wmask != '0);

    // a held load is retried every cycle until the overlap drains
    assign ld_addr = ld_wait ? ld_addr_q : dmem.addr;
    assign ld_mask = ld_wait ? ld_mask_q : dmem.rmask;
    assign ld_active = ld_wait || (dmem.req && dmem.rmask != '0);

    // youngest overlapping store wins
    always_comb begin
        hit = 1'b0;
        hit_mask = '0;
        hit_data = '0;
        scan_slot = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            scan_slot = head[SB_W-1:0] + SB_W'(i);
            if ((SB_W + 1)'(i) < count && sb_addr[scan_slot][31:2] == ld_addr[31:2]
                && (sb_mask[scan_slot] & ld_mask) != '0) begin
                hit = 1'b1;
                hit_mask = sb_mask[scan_slot];
                hit_data = sb_data[scan_slot];
            end
        end
    end

    assign ld_fwd = ld_active && hit && ((hit_mask & ld_mask) == ld_mask);
    assign ld_sram = ld_active && !hit;
    assign drain = (count != '0) && !ld_sram;

    assign sram.en = ld_sram || drain;
    assign sram.we = drain;
    assign sram.addr = ld_sram ? ld_addr[2 +: SRAM_AW] : sb_addr[head[SB_W-1:0]][2 +: SRAM_AW];
    assign sram.wmask = sb_mask[head[SB_W-1:0]];
    assign sram.wdata = sb_data[head[SB_W-1:0]];

    assign dmem.resp = resp_q;
    assign dmem.rdata = fwd_q ? fwd_data : sram.rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            resp_q <= 1'b0;
            fwd_q <= 1'b0;
            ld_wait <= 1'b0;
        end else begin
            resp_q <= push || ld_fwd || ld_sram;
            fwd_q <= ld_fwd;
            ld_wait <= ld_active && hit && !ld_fwd;
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (drain) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            sb_addr[tail[SB_W-1:0]] <= dmem.addr;
            sb_mask[tail[SB_W-1:0]] <= dmem.wmask;
            sb_data[tail[SB_W-1:0]] <= dmem.wdata;
        end
        if (dmem.req) begin
            ld_addr_q <= dmem.addr;
            ld_mask_q <= dmem.rmask;
        end
        if (ld_fwd) begin
            fwd_data <= hit_data;
        end
    end

    push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !dmem.full);

endmodule

/* tests/tb_lsu_top.sv */
`timescale 1ns/100ps
`include "lsq_defines.svh"

module tb_lsu_top;
    import lsq_pkg::*;

    // roughly five cycles per access, about forty accesses, plus reset
    localparam int TEST_CYCLES = 8 + 5 * 40;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       flush;
    logic       enq_valid;
    mem_op_e    enq_op;
    mem_funct3_e enq_funct3;
    rob_idx_t   enq_rob;
    phys_reg_t  enq_pd;
    arch_reg_t  enq_rd;
    lsq_idx_t   enq_idx;
    logic       addr_valid;
    lsq_idx_t   addr_idx;
    word_t      addr;
    word_t      store_data;
    rob_idx_t   commit_rob;
    logic       cdb_valid;
    rob_idx_t   cdb_rob;
    phys_reg_t  cdb_pd;
    arch_reg_t  cdb_rd;
    word_t      cdb_value;
    logic       full;

    logic [31:0] lfsr = 32'hba1f_4b45;
    logic [7:0]  ref_mem [1024];
    rob_idx_t    next_rob = '0;
    mem_op_e     acc_op [1 << `ROB_BITS];
    mem_funct3_e acc_f3 [1 << `ROB_BITS];
    phys_reg_t   acc_pd [1 << `ROB_BITS];
    arch_reg_t   acc_rd [1 << `ROB_BITS];
    word_t       acc_addr [1 << `ROB_BITS];
    word_t       acc_data [1 << `ROB_BITS];
    logic [(1 << `ROB_BITS)-1:0] flushed = '0;
    rob_idx_t    exp_rob [64];
    phys_reg_t   exp_pd [64];
    arch_reg_t   exp_rd [64];
    word_t       exp_val [64];
    int          wr_ptr = 0;
    int          rd_ptr = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;

    lsu_top lsu_top_inst (.*);

    always #4 clk = ~clk;

    // results must come back in commit order with the predicted contents
    cdb_matches: assert property (@(posedge clk) disable iff (!rst_n)
        cdb_valid |-> rd_ptr != wr_ptr && cdb_rob == exp_rob[rd_ptr] && cdb_pd == exp_pd[rd_ptr]
            && cdb_rd == exp_rd[rd_ptr] && cdb_value == exp_val[rd_ptr])
        else begin
            $display("Error %0t: cdb rob %0d value %h, expected rob %0d value %h",
                     $time, $sampled(cdb_rob), $sampled(cdb_value),
                     exp_rob[$sampled(rd_ptr)], exp_val[$sampled(rd_ptr)]);
            errors++;
        end

    no_flushed_result: assert property (@(posedge clk) disable iff (!rst_n)
        cdb_valid |-> !flushed[cdb_rob])
        else begin
            $display("a flushed access with rob %0d showed up on the result bus",
                     $sampled(cdb_rob));
            errors++;
        end

    always @(posedge clk) begin
        if (rst_n && cdb_valid && rd_ptr != wr_ptr) begin
            rd_ptr <= rd_ptr + 1;
        end
    end

    initial begin
        #(TEST_CYCLES * 4 * 8);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t word_addr();
        logic [31:0] r;
        r = take_bits(8);
        return {22'd0, r[7:0], 2'b00};
    endfunction

    function automatic word_t expected_load(input mem_funct3_e f3, input word_t byte_addr);
        logic [9:0]  a;
        logic [15:0] h;
        a = byte_addr[9:0];
        h = {ref_mem[a + 10'd1], ref_mem[a]};
        case (f3)
            f3_byte:   return {{24{h[7]}}, h[7:0]};
            f3_byte_u: return {24'd0, h[7:0]};
            f3_half:   return {{16{h[15]}}, h};
            f3_half_u: return {16'd0, h};
            default:   return {ref_mem[a + 10'd3], ref_mem[a + 10'd2], h};
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests++;
        if (errors == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic enqueue(input mem_op_e op, input mem_funct3_e f3,
                           output lsq_idx_t idx, output rob_idx_t rob);
        while (full) begin
            step();
        end
        idx = enq_idx;
        rob = next_rob;
        acc_op[rob] = op;
        acc_f3[rob] = f3;
        acc_pd[rob] = phys_reg_t'(take_bits(`PHYS_BITS));
        acc_rd[rob] = arch_reg_t'(take_bits(`ARCH_BITS));
        enq_valid = 1'b1;
        enq_op = op;
        enq_funct3 = f3;
        enq_rob = rob;
        enq_pd = acc_pd[rob];
        enq_rd = acc_rd[rob];
        step();
        enq_valid = 1'b0;
        next_rob++;
    endtask

    task automatic fill_address(input lsq_idx_t idx, input rob_idx_t rob,
                                input word_t a, input word_t d);
        acc_addr[rob] = a;
        acc_data[rob] = d;
        addr_valid = 1'b1;
        addr_idx = idx;
        addr = a;
        store_data = d;
        step();
        addr_valid = 1'b0;
    endtask

    task automatic commit_and_wait(input rob_idx_t rob);
        logic [9:0] a;
        word_t      d;
        int         waited;
        a = acc_addr[rob][9:0];
        d = acc_data[rob];
        waited = 0;
        exp_rob[wr_ptr] = rob;
        exp_pd[wr_ptr] = acc_pd[rob];
        if (acc_op[rob] == op_store) begin
            exp_rd[wr_ptr] = '0;
            exp_val[wr_ptr] = '0;
            ref_mem[a] = d[7:0];
            if (acc_f3[rob] != f3_byte) begin
                ref_mem[a + 10'd1] = d[15:8];
            end
            if (acc_f3[rob] == f3_word) begin
                ref_mem[a + 10'd2] = d[23:16];
                ref_mem[a + 10'd3] = d[31:24];
            end
        end else begin
            exp_rd[wr_ptr] = acc_rd[rob];
            exp_val[wr_ptr] = expected_load(acc_f3[rob], acc_addr[rob]);
        end
        wr_ptr++;
        commit_rob = rob;
        while (rd_ptr != wr_ptr && waited < 50) begin
            step();
            waited++;
        end
        if (rd_ptr != wr_ptr) begin
            $display("no result for rob %0d within 50 cycles", rob);
            errors++;
        end
    endtask

    task automatic single_access(input mem_op_e op, input mem_funct3_e f3,
                                 input word_t a, input word_t d);
        lsq_idx_t idx;
        rob_idx_t rob;
        enqueue(op, f3, idx, rob);
        fill_address(idx, rob, a, d);
        commit_and_wait(rob);
    endtask

    initial begin
        word_t    a;
        word_t    a1;
        lsq_idx_t idx_before;
        lsq_idx_t ids [`LSQ_DEPTH];
        rob_idx_t robs [`LSQ_DEPTH];
        int       start;
        rst_n = 1'b0;
        flush = 1'b0;
        enq_valid = 1'b0;
        enq_op = op_load;
        enq_funct3 = f3_word;
        enq_rob = '0;
        enq_pd = '0;
        enq_rd = '0;
        addr_valid = 1'b0;
        addr_idx = '0;
        addr = '0;
        store_data = '0;
        commit_rob = '1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        start = errors;
        a1 = word_addr();
        single_access(op_store, f3_word, a1, take_bits(32));
        single_access(op_load, f3_word, a1, 32'd0);
        finish_test("word store then load", start);

        start = errors;
        a = word_addr();
        single_access(op_store, f3_word, a, take_bits(32));
        for (int i = 0; i < 4; i++) begin
            single_access(op_load, f3_byte, a + word_t'(i), 32'd0);
            single_access(op_load, f3_byte_u, a + word_t'(i), 32'd0);
        end
        for (int i = 0; i < 4; i += 2) begin
            single_access(op_load, f3_half, a + word_t'(i), 32'd0);
            single_access(op_load, f3_half_u, a + word_t'(i), 32'd0);
        end
        finish_test("byte and half loads", start);

        // four byte stores merge into one word
        start = errors;
        a = word_addr();
        for (int i = 0; i < 4; i++) begin
            enqueue(op_store, f3_byte, ids[i], robs[i]);
        end
        enqueue(op_load, f3_word, ids[4], robs[4]);
        for (int i = 0; i < 4; i++) begin
            fill_address(ids[i], robs[i], a + word_t'(i), take_bits(32));
        end
        fill_address(ids[4], robs[4], a, 32'd0);
        for (int i = 0; i < 5; i++) begin
            commit_and_wait(robs[i]);
        end
        finish_test("byte store merge", start);

        start = errors;
        a = word_addr();
        enqueue(op_load, f3_word, ids[0], robs[0]);
        enqueue(op_store, f3_word, ids[1], robs[1]);
        enqueue(op_load, f3_word, ids[2], robs[2]);
        fill_address(ids[0], robs[0], a1, 32'd0);
        fill_address(ids[1], robs[1], a, take_bits(32));
        fill_address(ids[2], robs[2], a, 32'd0);
        // addresses ready but nothing committed yet
        repeat (4) step();
        for (int i = 0; i < 3; i++) begin
            commit_and_wait(robs[i]);
        end
        finish_test("commit order", start);

        start = errors;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            enqueue(op_load, f3_word, ids[i], robs[i]);
            flushed[robs[i]] = 1'b1;
        end
        assert (full) else begin
            $display("Error %0t: full is low with %0d entries queued", $time, `LSQ_DEPTH);
            errors++;
        end
        idx_before = enq_idx;
        flushed[next_rob] = 1'b1;
        enq_valid = 1'b1;
        enq_rob = next_rob;
        step();
        enq_valid = 1'b0;
        next_rob++;
        assert (enq_idx == idx_before) else begin
            $display("Error %0t: enq_idx moved to %0d on a full queue", $time, enq_idx);
            errors++;
        end
        finish_test("full queue", start);

        start = errors;
        // the oldest flushed load is ready and committed when the flush hits
        fill_address(ids[0], robs[0], a1, 32'd0);
        commit_rob = robs[0];
        flush = 1'b1;
        step();
        flush = 1'b0;
        assert (!full) else begin
            $display("Error %0t: full still high after flush", $time);
            errors++;
        end
        a = word_addr();
        single_access(op_store, f3_word, a, take_bits(32));
        single_access(op_load, f3_word, a, 32'd0);
        repeat (4) step();
        finish_test("flush", start);

        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
